/* Makefile */
TOP = tb_divsqrt

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f divsqrt_top.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* divsqrt_classify.sv */
// ----------------------------------------
// operand classification stage
// special results, result exponent, aligned mantissas
// ----------------------------------------
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module divsqrt_classify
  import fp_pkg::*;
  import divsqrt_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          flush_i,
  input  logic          valid_i,
  output logic          ready_o,
  input  divsqrt_req_t  req_i,
  output logic          valid_o,
  input  logic          ready_i,
  output divsqrt_prep_t prep_o
);

  localparam logic signed [EXP_W-1:0] BIAS = EXP_W'(`EXP_BIAS);

  fp32_u                   a, b;
  logic                    a_zero, a_inf, a_nan;
  logic                    b_zero, b_inf, b_nan;
  logic signed [EXP_W-1:0] ea, eb, e_unb;
  divsqrt_prep_t           prep_d, prep_q;
  logic                    valid_q;

  assign a = req_i.op_a;
  assign b = req_i.op_b;

  // ----------------------------------------
  // operand classes
  // ----------------------------------------
  // subnormals land in the zero class
  assign a_zero = (a.fields.exponent == '0);
  assign a_inf  = (a.fields.exponent == '1) && (a.fields.mantissa == '0);
  assign a_nan  = (a.fields.exponent == '1) && (a.fields.mantissa != '0);
  assign b_zero = (b.fields.exponent == '0);
  assign b_inf  = (b.fields.exponent == '1) && (b.fields.mantissa == '0);
  assign b_nan  = (b.fields.exponent == '1) && (b.fields.mantissa != '0);

  assign ea    = $signed({2'b00, a.fields.exponent});
  assign eb    = $signed({2'b00, b.fields.exponent});
  assign e_unb = ea - BIAS;        // unbiased radicand exponent

  always_comb begin
    prep_d                    = '0;
    prep_d.op                 = req_i.op;
    prep_d.tag                = req_i.tag;
    prep_d.special_res.raw    = CANON_NAN;
    if (req_i.op == OP_DIV) begin
      prep_d.sign  = a.fields.sign ^ b.fields.sign;
      prep_d.exp   = ea - eb + BIAS;
      prep_d.man_a = {2'b00, 1'b1, a.fields.mantissa};  // plain 1.f, no shift
      prep_d.man_b = {1'b1, b.fields.mantissa};
      if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
        prep_d.special           = 1'b1;
        prep_d.special_status.nv = 1'b1;
      end else if (a_inf || b_zero) begin
        prep_d.special                     = 1'b1;
        prep_d.special_res.fields.sign     = prep_d.sign;
        prep_d.special_res.fields.exponent = '1;
        prep_d.special_res.fields.mantissa = '0;
        prep_d.special_status.dz           = ~a_inf;  // only finite / 0
      end else if (a_zero || b_inf) begin
        prep_d.special                     = 1'b1;
        prep_d.special_res.fields.sign     = prep_d.sign;
        prep_d.special_res.fields.exponent = '0;
        prep_d.special_res.fields.mantissa = '0;
      end
    end else begin
      // root exponent is floor(e/2), odd e moves one into the radicand
      prep_d.sign  = 1'b0;
      prep_d.exp   = (e_unb >>> 1) + BIAS;
      prep_d.man_a = e_unb[0] ? {1'b1, a.fields.mantissa, 2'b00}
                              : {2'b01, a.fields.mantissa, 1'b0};
      if (a_nan || (a.fields.sign && !a_zero)) begin
        prep_d.special           = 1'b1;
        prep_d.special_status.nv = 1'b1;
      end else if (a_zero) begin
        prep_d.special                     = 1'b1;  // sqrt(-0) keeps its sign
        prep_d.special_res.fields.sign     = a.fields.sign;
        prep_d.special_res.fields.exponent = '0;
        prep_d.special_res.fields.mantissa = '0;
      end else if (a_inf) begin
        prep_d.special     = 1'b1;
        prep_d.special_res = a;                      // +inf passes through
      end
    end
  end

  // ----------------------------------------
  // stage register
  // ----------------------------------------
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      prep_q <= prep_d;
    end
  end

  assign valid_o = valid_q;
  assign prep_o  = prep_q;

endmodule

/* divsqrt_config.svh */
// ----------------------------------------
// divsqrt configuration
// float format widths, recurrence length and tag width
// ----------------------------------------
`ifndef DIVSQRT_CONFIG_SVH
`define DIVSQRT_CONFIG_SVH

// fp32 word layout
`define FP_WIDTH  32
`define EXP_BITS  8
`define MAN_BITS  23   // stored fraction, hidden one not included
`define EXP_BIAS  127

// result bits from the recurrence
// 24 significant bits plus two for normalization and sticky
`define QUOT_BITS 26

// tag carried alongside each operation
`define TAG_BITS  8

`endif

/* divsqrt_iter.sv */
// ----------------------------------------
// radix-2 divide / square root recurrence
// control fsm, hold register, result packing
// ----------------------------------------
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module divsqrt_iter
  import fp_pkg::*;
  import divsqrt_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          flush_i,
  input  logic          valid_i,
  output logic          ready_o,
  input  divsqrt_prep_t prep_i,
  output logic          valid_o,
  input  logic          ready_i,
  output divsqrt_rsp_t  rsp_o,
  output logic          busy_o
);

  localparam int unsigned CNT_W   = $clog2(`QUOT_BITS + 1);
  localparam int unsigned REM_W   = `QUOT_BITS + 2;
  localparam int          EXP_MAX = (1 << `EXP_BITS) - 2;  // largest normal

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} fsm_state_e;

  fsm_state_e              state_q, state_d;
  logic                    accept, step, done;
  logic                    out_valid, hold_result, use_held;
  logic [CNT_W-1:0]        cnt_q;       // bits still to produce
  divsqrt_prep_t           prep_q;      // operation context
  logic [REM_W-1:0]        rem_q, cand, trial, diff, rem_sel, rem_d;
  logic [`QUOT_BITS-1:0]   quot_q, rad_q;
  logic                    ge;
  logic                    norm, lost;
  logic signed [EXP_W-1:0] exp_f;
  logic [`MAN_BITS-1:0]    man;
  divsqrt_rsp_t            unit_rsp, held_rsp_q;

  // ----------------------------------------
  // control fsm
  // ----------------------------------------
  assign done = (state_q == BUSY) && (cnt_q == '0);
  assign step = (state_q == BUSY) && (cnt_q != '0);

  always_comb begin
    state_d     = state_q;
    ready_o     = 1'b0;
    out_valid   = 1'b0;
    hold_result = 1'b0;
    use_held    = 1'b0;
    unique case (state_q)
      IDLE: begin
        ready_o = 1'b1;
        if (valid_i) state_d = BUSY;
      end
      BUSY: begin
        if (done) begin
          out_valid = 1'b1;
          if (ready_i) begin
            ready_o = 1'b1;                          // back-to-back start
            state_d = valid_i ? BUSY : IDLE;
          end else begin
            hold_result = 1'b1;                      // park result
            state_d     = HOLD;
          end
        end
      end
      HOLD: begin
        out_valid = 1'b1;
        use_held  = 1'b1;
        if (ready_i) begin
          ready_o = 1'b1;
          state_d = valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // flush wins over everything
    if (flush_i) begin
      out_valid = 1'b0;
      state_d   = IDLE;
    end
  end

  assign accept = valid_i & ready_o & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        if (prep_i.special)         cnt_q <= '0;  // answer known already
        else if (prep_i.op == OP_DIV) cnt_q <= CNT_W'(`QUOT_BITS);
        else                        cnt_q <= CNT_W'(`QUOT_BITS - 1);  // root in [1,2)
      end else if (step) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ----------------------------------------
  // recurrence step
  // ----------------------------------------
  always_comb begin
    if (prep_q.op == OP_DIV) begin
      cand  = rem_q;
      trial = REM_W'(prep_q.man_b);
    end else begin
      // bring down the next radicand pair, trial is 4q+1
      cand  = {rem_q[REM_W-3:0], rad_q[`QUOT_BITS-1 -: 2]};
      trial = {quot_q, 2'b01};
    end
    ge      = (cand >= trial);
    diff    = cand - trial;
    rem_sel = ge ? diff : cand;                      // restoring
    rem_d   = (prep_q.op == OP_DIV) ? {rem_sel[REM_W-2:0], 1'b0} : rem_sel;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      prep_q <= prep_i;
      rem_q  <= (prep_i.op == OP_DIV) ? REM_W'(prep_i.man_a) : '0;
      quot_q <= '0;
      rad_q  <= prep_i.man_a;
    end else if (step) begin
      rem_q  <= rem_d;
      quot_q <= {quot_q[`QUOT_BITS-2:0], ge};        // one bit per cycle
      rad_q  <= {rad_q[`QUOT_BITS-3:0], 2'b00};
    end
  end

  // ----------------------------------------
  // normalize, truncate, pack
  // ----------------------------------------
  always_comb begin
    norm  = quot_q[`QUOT_BITS-1];                    // div quotient >= 1
    man   = norm ? quot_q[`QUOT_BITS-2 -: `MAN_BITS] : quot_q[`QUOT_BITS-3 -: `MAN_BITS];
    lost  = (norm ? |quot_q[1:0] : quot_q[0]) | (rem_q != '0);
    exp_f = prep_q.exp - EXP_W'((prep_q.op == OP_DIV) && !norm);
    unit_rsp     = '0;
    unit_rsp.tag = prep_q.tag;
    if (prep_q.special) begin
      unit_rsp.result = prep_q.special_res;
      unit_rsp.status = prep_q.special_status;
    end else if (exp_f > EXP_MAX) begin
      // toward zero saturates at max finite
      unit_rsp.result.fields.sign     = prep_q.sign;
      unit_rsp.result.fields.exponent = `EXP_BITS'(EXP_MAX);
      unit_rsp.result.fields.mantissa = '1;
      unit_rsp.status.of              = 1'b1;
      unit_rsp.status.nx              = 1'b1;
    end else if (exp_f < 1) begin
      unit_rsp.result.fields.sign = prep_q.sign;     // flush to signed zero
      unit_rsp.status.uf          = 1'b1;
      unit_rsp.status.nx          = 1'b1;
    end else begin
      unit_rsp.result.fields.sign     = prep_q.sign;
      unit_rsp.result.fields.exponent = exp_f[`EXP_BITS-1:0];
      unit_rsp.result.fields.mantissa = man;
      unit_rsp.status.nx              = lost;
    end
  end

  // hold register, written when downstream stalls
  always_ff @(posedge clk_i) begin
    if (hold_result) begin
      held_rsp_q <= unit_rsp;
    end
  end

  assign valid_o = out_valid;
  assign rsp_o   = use_held ? held_rsp_q : unit_rsp;
  assign busy_o  = (state_q != IDLE);

  // recurrence must run to the last bit unless flushed
  a_busy_runs: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == BUSY && cnt_q != '0 && !flush_i) |=> (state_q == BUSY));

  a_flush_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> !valid_o);

endmodule

/* divsqrt_pkg.sv */
// ----------------------------------------
// divsqrt transactions
// request, prepared operation, response
// ----------------------------------------
`include "divsqrt_config.svh"

package divsqrt_pkg;

  // exponent with sign and headroom for over/underflow
  localparam int unsigned EXP_W = `EXP_BITS + 2;

  typedef struct packed {
    fp_pkg::fp32_u         op_a;  // dividend or radicand
    fp_pkg::fp32_u         op_b;  // divisor, ignored for sqrt
    fp_pkg::fp_op_e        op;
    logic [`TAG_BITS-1:0]  tag;
  } divsqrt_req_t;

  // classified operation handed to the recurrence
  typedef struct packed {
    logic                     special;         // result already known
    fp_pkg::fp32_u            special_res;
    fp_pkg::fp_status_t       special_status;
    logic                     sign;
    logic signed [EXP_W-1:0]  exp;             // biased, before normalization
    logic [`QUOT_BITS-1:0]    man_a;           // 2 int bits for sqrt alignment
    logic [`MAN_BITS:0]       man_b;           // divisor with hidden one
    fp_pkg::fp_op_e           op;
    logic [`TAG_BITS-1:0]     tag;
  } divsqrt_prep_t;

  typedef struct packed {
    fp_pkg::fp32_u         result;
    fp_pkg::fp_status_t    status;
    logic [`TAG_BITS-1:0]  tag;
  } divsqrt_rsp_t;

endpackage

/* divsqrt_stage_reg.sv */
// ----------------------------------------
// elastic pipeline register
// one valid/ready stage with flush
// ----------------------------------------
`timescale 1ns/1ps

module divsqrt_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flush_i,
  // upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // accept when downstream drains us or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;             // flush drops whatever sits here
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // stalled payload must not move under the consumer
  a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !ready_i) |=> $stable(data_o));

endmodule

/* divsqrt_top.f */
+incdir+.
fp_pkg.sv
divsqrt_pkg.sv
divsqrt_stage_reg.sv
divsqrt_classify.sv
divsqrt_iter.sv
divsqrt_top.sv
tb_divsqrt.sv

/* divsqrt_top.sv */
// ----------------------------------------
// fp32 divide / square root unit
// input reg, classify, recurrence, output reg
// ----------------------------------------
`timescale 1ns/1ps

module divsqrt_top
  import divsqrt_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         flush_i,
  // request side
  input  logic         in_valid_i,
  output logic         in_ready_o,
  input  divsqrt_req_t req_i,
  // response side
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output divsqrt_rsp_t rsp_o,
  output logic         busy_o
);

  logic          in_valid, in_ready;   // input reg -> classify
  divsqrt_req_t  in_req;
  logic          cls_valid, cls_ready; // classify -> recurrence
  divsqrt_prep_t cls_prep;
  logic          it_valid, it_ready, it_busy;
  divsqrt_rsp_t  it_rsp;

  // ----------------------------------------
  // stage chain
  // ----------------------------------------
  divsqrt_stage_reg #(
    .payload_t ( divsqrt_req_t )
  ) i_in_reg (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .flush_i ( flush_i    ),
    .valid_i ( in_valid_i ),
    .ready_o ( in_ready_o ),
    .data_i  ( req_i      ),
    .valid_o ( in_valid   ),
    .ready_i ( in_ready   ),
    .data_o  ( in_req     )
  );

  divsqrt_classify i_classify (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .flush_i ( flush_i   ),
    .valid_i ( in_valid  ),
    .ready_o ( in_ready  ),
    .req_i   ( in_req    ),
    .valid_o ( cls_valid ),
    .ready_i ( cls_ready ),
    .prep_o  ( cls_prep  )
  );

  divsqrt_iter i_iter (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .flush_i ( flush_i   ),
    .valid_i ( cls_valid ),
    .ready_o ( cls_ready ),
    .prep_i  ( cls_prep  ),
    .valid_o ( it_valid  ),
    .ready_i ( it_ready  ),
    .rsp_o   ( it_rsp    ),
    .busy_o  ( it_busy   )
  );

  divsqrt_stage_reg #(
    .payload_t ( divsqrt_rsp_t )
  ) i_out_reg (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .flush_i ( flush_i     ),
    .valid_i ( it_valid    ),
    .ready_o ( it_ready    ),
    .data_i  ( it_rsp      ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .data_o  ( rsp_o       )
  );

  // anything in flight anywhere
  assign busy_o = in_valid | cls_valid | it_busy | out_valid_o;

endmodule

/* fp_pkg.sv */
// ----------------------------------------
// fp32 number format
// word views, exception flags, op code
// ----------------------------------------
`include "divsqrt_config.svh"

package fp_pkg;

  // sign / exponent / fraction split of one word
  typedef struct packed {
    logic                 sign;
    logic [`EXP_BITS-1:0] exponent;
    logic [`MAN_BITS-1:0] mantissa;
  } fp32_fields_t;

  // same word, decoded either as a whole or by field
  typedef union packed {
    logic [`FP_WIDTH-1:0] raw;
    fp32_fields_t         fields;
  } fp32_u;

  // ieee exception flags, msb first as in fflags
  typedef struct packed {
    logic nv;  // invalid
    logic dz;  // divide by zero
    logic of;  // overflow
    logic uf;  // underflow
    logic nx;  // inexact
  } fp_status_t;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } fp_op_e;

  // quiet nan returned for every invalid result
  localparam logic [`FP_WIDTH-1:0] CANON_NAN = 32'h7fc00000;

endpackage

/* tb_divsqrt.sv */
// ----------------------------------------
// testbench for the fp32 divide / sqrt unit
// reference ring of expected responses, checked by assertions
// ----------------------------------------
`timescale 1ns/1ps
`include "divsqrt_config.svh"

module tb_divsqrt
  import fp_pkg::*;
  import divsqrt_pkg::*;
();

  localparam int         LIMIT = 2000;      // cycles allowed per wait
  localparam fp_status_t ST_NV = 5'b10000;
  localparam fp_status_t ST_DZ = 5'b01000;
  localparam fp_status_t ST_NX = 5'b00001;

  logic                 clk_i, reset_i, flush_i;
  logic                 in_valid_i, in_ready_o, out_valid_o, out_ready_i, busy_o;
  divsqrt_req_t         req_i;
  divsqrt_rsp_t         rsp_o, cur_exp;     // cur_exp rides along with req_i
  divsqrt_rsp_t         exp_mem [256];      // expected responses, in request order
  logic [7:0]           wr_ptr, rd_ptr;
  logic [`TAG_BITS-1:0] tag_cnt;
  logic                 stall_en;
  int                   seed = 32'hb27a;
  int                   stall_seed = 32'hb27a;
  int                   errors = 0;
  int                   checks = 0;
  int                   tests = 0;
  int                   err_mark = 0;

  divsqrt_top i_dut (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .req_i       ( req_i       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .rsp_o       ( rsp_o       ),
    .busy_o      ( busy_o      )
  );

  always #20 clk_i = ~clk_i;

  // random back-pressure, ready about 3 cycles in 4
  always @(posedge clk_i) begin
    #2;
    out_ready_i = stall_en ? (($random(stall_seed) & 3) != 0) : 1'b1;
  end

  // ----------------------------------------
  // reference ring, push on accept, pop on response
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (flush_i) begin
      rd_ptr <= wr_ptr;                     // flushed ops never answer
    end else begin
      if (in_valid_i && in_ready_o) begin
        exp_mem[wr_ptr] <= cur_exp;
        wr_ptr          <= wr_ptr + 1'b1;
      end
      if (out_valid_o && out_ready_i) begin
        rd_ptr <= rd_ptr + 1'b1;
        checks <= checks + 1;
      end
    end
  end

  a_rsp_match: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && out_ready_i) |-> (rd_ptr != wr_ptr && rsp_o == exp_mem[rd_ptr]))
    else begin
      errors++;
      $display("ERROR at %0t: got %h flags %b tag %0d, expected %h flags %b tag %0d",
               $time, $sampled(rsp_o.result.raw), $sampled(rsp_o.status),
               $sampled(rsp_o.tag), exp_mem[$sampled(rd_ptr)].result.raw,
               exp_mem[$sampled(rd_ptr)].status, exp_mem[$sampled(rd_ptr)].tag);
    end

  a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(rsp_o)))
    else begin
      errors++;
      $display("ERROR at %0t: response changed or dropped while stalled", $time);
    end

  a_flush_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> (!out_valid_o && !busy_o))
    else begin
      errors++;
      $display("ERROR at %0t: out_valid_o or busy_o high after flush", $time);
    end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  // exact integer to fp32, k below 2**24
  function automatic logic [31:0] int_to_fp(input logic [23:0] k);
    int          pos;
    logic [23:0] m;
    pos = 0;
    for (int i = 0; i < 24; i++) begin
      if (k[i]) pos = i;
    end
    m = k << (23 - pos);                    // hidden one lands on bit 23
    return {1'b0, 8'(127 + pos), m[22:0]};
  endfunction

  task automatic send(input logic [31:0] a, input logic [31:0] b, input fp_op_e op,
                      input logic [31:0] res, input fp_status_t st);
    int n;
    req_i.op_a.raw   = a;
    req_i.op_b.raw   = b;
    req_i.op         = op;
    req_i.tag        = tag_cnt;
    cur_exp.result.raw = res;
    cur_exp.status   = st;
    cur_exp.tag      = tag_cnt;
    in_valid_i       = 1'b1;
    n = 0;
    @(posedge clk_i);
    while (!in_ready_o && n < LIMIT) begin
      n++;
      @(posedge clk_i);
    end
    #2;
    in_valid_i = 1'b0;
    tag_cnt    = tag_cnt + 1'b1;
    if (n >= LIMIT) report_timeout("in_ready_o");
  endtask

  // normal operand over a power of two, 0.5 up to 8
  task automatic send_exact_div();
    logic [31:0] r;
    int          p, e;
    r = $random(seed);
    p = int'(r[2:0] % 3'd5) - 1;
    e = 10 + int'(r[10:3]) % 230;           // keeps e - p inside the normal range
    send({r[31], 8'(e), r[30:8]}, {1'b0, 8'(127 + p), 23'd0}, OP_DIV,
         {r[31], 8'(e - p), r[30:8]}, '0);
  endtask

  task automatic send_exact_sqrt();
    logic [31:0] r;
    logic [23:0] k;
    r = $random(seed);
    k = {12'd0, r[11:0]};
    if (k == 0) k = 24'd1;
    send(int_to_fp(k * k), 32'd0, OP_SQRT, int_to_fp(k), '0);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(posedge clk_i);
    while ((rd_ptr != wr_ptr || busy_o) && n < LIMIT) begin
      n++;
      @(posedge clk_i);
    end
    #2;
    if (n >= LIMIT) report_timeout("outstanding responses");
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%s: %s", name, (errors == err_mark) ? "passed" : "failed");
    err_mark = errors;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] r;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    req_i      = '0;
    out_ready_i = 1'b1;
    cur_exp    = '0;
    stall_en   = 1'b0;
    tag_cnt    = '0;
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    repeat (20) send_exact_div();
    wait_drain();
    finish_test("exact divide");

    repeat (20) send_exact_sqrt();
    send(32'h3f800000, 32'h40400000, OP_DIV, 32'h3eaaaaaa, ST_NX);  // 1/3 truncated
    wait_drain();
    finish_test("exact sqrt");

    r = $random(seed);
    send({r[31], 8'h85, r[22:0]}, {r[30], 31'd0}, OP_DIV, {r[31] ^ r[30], 8'hff, 23'd0}, ST_DZ);
    send(32'h00000000, 32'h80000000, OP_DIV, CANON_NAN, ST_NV);
    send(32'hbf800000, 32'h00000000, OP_SQRT, CANON_NAN, ST_NV);
    send(32'h7fc12345, 32'h3f800000, OP_DIV, CANON_NAN, ST_NV);
    send(32'h40000000, 32'hff800001, OP_DIV, CANON_NAN, ST_NV);
    wait_drain();
    finish_test("special cases");

    stall_en = 1'b1;
    repeat (15) begin
      send_exact_div();
      send_exact_sqrt();
      // one-cycle specials right behind a long op meet a full output reg
      send(32'h3f800000, 32'h80000000, OP_DIV, 32'hff800000, ST_DZ);
      send(32'hc0000000, 32'h80000000, OP_DIV, 32'h7f800000, ST_DZ);
    end
    wait_drain();
    stall_en = 1'b0;
    finish_test("back-pressure");

    send_exact_div();
    repeat (5) @(posedge clk_i);            // mid recurrence
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    send_exact_sqrt();
    wait_drain();
    finish_test("flush");

    $display("tests %0d, responses checked %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
